// File: rtl/fetch_pkg.sv
package fetch_pkg;

    parameter int xlen = 32;

    typedef logic [xlen-1:0] inst_t;
    typedef logic [xlen-1:0] addr_t;

    // only the control-transfer opcodes matter to fetch
    typedef enum logic [6:0] {
        op_jal  = 7'b1101111,
        op_jalr = 7'b1100111,
        op_br   = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        st_start = 2'b00, // about to issue
        st_wait  = 2'b01, // response pending
        st_drain = 2'b10, // stale response pending after redirect
        st_full  = 2'b11  // parked until the queue has room
    } fetch_state_e;

    // one queue slot, 97 bits
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  pred_taken;
        addr_t pred_target;
    } fetch_entry_t;

    // back-end btb update, 65 bits
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
    } btb_write_t;

    // mispredict recovery, 33 bits
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

endpackage

// File: rtl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush_i,
    input  logic         enq_i,
    input  fetch_entry_t enq_entry_i,
    input  logic         deq_i,
    output fetch_entry_t head_o,
    output logic         full_o,
    output logic         empty_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic             do_enq;
    logic             do_deq;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[head_q];

    assign do_enq = enq_i && !full_o && !flush_i;
    assign do_deq = deq_i && !empty_o && !flush_i; // flush wins

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail_q] <= enq_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0; // drop everything in flight
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (do_deq) begin
                head_q <= ptr_inc(head_q);
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

endmodule

// File: rtl/btb.sv
`timescale 1ns/1ps

module btb
    import fetch_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en_i,
    input  logic [BTB_INDEX_BITS-1:0] rd_idx_i,
    input  btb_write_t                wr_i,
    output logic                      hit_o,
    output addr_t                     target_o
);

    localparam int ENTRIES = 1 << BTB_INDEX_BITS;

    // tagless, so pcs sharing index bits alias onto one entry
    addr_t                     target_mem [ENTRIES];
    logic [ENTRIES-1:0]        valid_q;
    logic [BTB_INDEX_BITS-1:0] wr_idx;

    assign wr_idx = wr_i.pc[BTB_INDEX_BITS+1:2]; // word-aligned index

    // target array
    always_ff @(posedge clk) begin
        if (wr_i.valid) begin
            target_mem[wr_idx] <= wr_i.target;
        end
        if (rd_en_i) begin
            target_o <= target_mem[rd_idx_i]; // old data on same-cycle write
        end
    end

    // valid array
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            hit_o   <= 1'b0;
        end else begin
            if (wr_i.valid) begin
                valid_q[wr_idx] <= 1'b1;
            end
            if (rd_en_i) begin
                hit_o <= valid_q[rd_idx_i]; // held until the next lookup
            end
        end
    end

endmodule

// File: rtl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC       = 32'h1eceb000,
    parameter int    BTB_INDEX_BITS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  inst_t                     imem_rdata_i,
    input  logic                      imem_resp_i,
    input  redirect_t                 redirect_i,
    input  logic                      btb_hit_i,
    input  addr_t                     btb_target_i,
    input  logic                      queue_full_i,
    output logic                      imem_req_o,
    output addr_t                     imem_addr_o,
    output logic                      btb_rd_en_o,
    output logic [BTB_INDEX_BITS-1:0] btb_rd_idx_o,
    output logic                      enq_valid_o,
    output fetch_entry_t              enq_entry_o,
    output logic                      flush_o
);

    fetch_state_e state, state_next;
    addr_t        pc, pc_next;
    opcode_e      opcode;
    logic         is_branch;
    logic         pred_taken;
    logic         idle;
    logic         resp_ok;

    assign opcode     = opcode_e'(imem_rdata_i[6:0]);
    assign is_branch  = opcode inside {op_jal, op_jalr, op_br};
    assign pred_taken = is_branch && btb_hit_i; // btb result alone is not trusted

    assign idle = (state == st_start) || (state == st_full);

    // a redirect this cycle cancels the request for the old pc
    assign imem_req_o   = idle && !queue_full_i && !redirect_i.valid && !rst;
    assign imem_addr_o  = pc;
    assign btb_rd_en_o  = imem_req_o; // lookup rides along with the request
    assign btb_rd_idx_o = pc[BTB_INDEX_BITS+1:2];

    assign resp_ok     = (state == st_wait) && imem_resp_i && !redirect_i.valid;
    assign enq_valid_o = resp_ok;
    assign flush_o     = redirect_i.valid;

    assign enq_entry_o = '{
        inst:        imem_rdata_i,
        pc:          pc,
        pred_taken:  pred_taken,
        pred_target: pred_taken ? btb_target_i : addr_t'(0)
    };

    always_comb begin
        state_next = state;
        pc_next    = pc;
        if (redirect_i.valid) begin
            pc_next = redirect_i.pc;
            // still owed a response unless it shows up right now
            if ((state == st_wait || state == st_drain) && !imem_resp_i) begin
                state_next = st_drain;
            end else begin
                state_next = st_start;
            end
        end else begin
            case (state)
                st_start, st_full: begin
                    if (imem_req_o) begin
                        state_next = st_wait;
                    end else if (queue_full_i) begin
                        state_next = st_full; // hold off until a dequeue
                    end
                end
                st_wait: begin
                    if (imem_resp_i) begin
                        pc_next    = pred_taken ? btb_target_i : pc + addr_t'(4);
                        state_next = st_start;
                    end
                end
                st_drain: begin
                    if (imem_resp_i) begin
                        state_next = st_start; // stale word dropped
                    end
                end
                default: state_next = st_start;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_start;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            pc    <= pc_next;
        end
    end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC       = 32'h1eceb000,
    parameter int    BTB_INDEX_BITS = 8,
    parameter int    QUEUE_DEPTH    = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         imem_resp_i,
    input  inst_t        imem_rdata_i,
    input  redirect_t    redirect_i,
    input  btb_write_t   btb_wr_i,
    input  logic         deq_i,
    output logic         imem_req_o,
    output addr_t        imem_addr_o,
    output fetch_entry_t entry_o,
    output logic         empty_o
);

    logic                      btb_rd_en;
    logic [BTB_INDEX_BITS-1:0] btb_rd_idx;
    logic                      btb_hit;
    addr_t                     btb_target;
    logic                      enq_valid;
    fetch_entry_t              enq_entry;
    logic                      flush;
    logic                      queue_full;

    fetch_ctrl #(
        .RESET_PC       (RESET_PC),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .imem_rdata_i (imem_rdata_i),
        .imem_resp_i  (imem_resp_i),
        .redirect_i   (redirect_i),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .queue_full_i (queue_full),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .btb_rd_en_o  (btb_rd_en),
        .btb_rd_idx_o (btb_rd_idx),
        .enq_valid_o  (enq_valid),
        .enq_entry_o  (enq_entry),
        .flush_o      (flush)
    );

    btb #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .rd_en_i  (btb_rd_en),
        .rd_idx_i (btb_rd_idx),
        .wr_i     (btb_wr_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush),
        .enq_i       (enq_valid),
        .enq_entry_i (enq_entry),
        .deq_i       (deq_i),
        .head_o      (entry_o),
        .full_o      (queue_full),
        .empty_o     (empty_o)
    );

endmodule

// File: tests/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions
    import fetch_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      imem_req_i,
    input logic      imem_resp_i,
    input redirect_t redirect_i,
    input logic      queue_full_i,
    input logic      empty_i
);

    logic req_open_q; // request sent, response not back yet

    always_ff @(posedge clk) begin
        if (rst) begin
            req_open_q <= 1'b0;
        end else if (imem_req_i) begin
            req_open_q <= 1'b1;
        end else if (imem_resp_i) begin
            req_open_q <= 1'b0;
        end
    end

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        imem_req_i |-> !req_open_q)
        else $error("request issued while another is outstanding");

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !imem_req_i)
        else $error("request issued during reset");

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect_i.valid |=> empty_i)
        else $error("queue not empty after a redirect");

    no_req_when_full: assert property (@(posedge clk) disable iff (rst)
        queue_full_i |-> !imem_req_i)
        else $error("request issued while the queue is full");

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam addr_t RESET_PC    = 32'h1eceb000;
    localparam int    QUEUE_DEPTH = 8;
    localparam int    N_ROWS      = 6;
    localparam int    DEQ_TIMEOUT = 400;

    typedef struct packed {
        bit         restart;     // redirect to seed_pc before the row starts
        bit         hold;        // no dequeues until the queue has filled
        addr_t      seed_pc;
        bit         btb_wr;
        addr_t      btb_pc;
        addr_t      btb_tgt;
        int         n_deq;
        logic [7:0] deq_pattern; // one bit per cycle, repeating
        int         redir_at;    // dequeue count at which to redirect, -1 for none
        addr_t      redir_pc;
    } scenario_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         imem_resp_i;
    inst_t        imem_rdata_i;
    redirect_t    redirect_i;
    btb_write_t   btb_wr_i;
    logic         deq_i;
    logic         imem_req_o;
    addr_t        imem_addr_o;
    fetch_entry_t entry_o;
    logic         empty_o;

    scenario_t rows [N_ROWS];
    string     names [N_ROWS];
    int        n_rows_loaded;
    integer    seed;
    logic      pending;      // memory model owes a response
    addr_t     pend_addr;
    int        countdown;
    int        req_count;
    logic      redir_prev;
    addr_t     exp_pc;       // next pc of the expected stream
    logic      btb_valid_m [256];
    addr_t     btb_target_m [256];
    int        errors;
    int        timeouts;
    int        checks;

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .imem_resp_i  (imem_resp_i),
        .imem_rdata_i (imem_rdata_i),
        .redirect_i   (redirect_i),
        .btb_wr_i     (btb_wr_i),
        .deq_i        (deq_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .entry_o      (entry_o),
        .empty_o      (empty_o)
    );

    bind fetch_top fetch_assertions u_assertions (
        .clk          (clk),
        .rst          (rst),
        .imem_req_i   (imem_req_o),
        .imem_resp_i  (imem_resp_i),
        .redirect_i   (redirect_i),
        .queue_full_i (queue_full),
        .empty_i      (empty_o)
    );

    always #5 clk = ~clk;

    function automatic logic is_jal_addr(input addr_t a);
        return (a == RESET_PC + 32'h10) || (a == RESET_PC + 32'h410);
    endfunction

    // jal x1, 0 at the jal addresses, addi x1, x0, imm elsewhere
    function automatic inst_t mem_word(input addr_t a);
        logic [11:0] imm;
        imm = a[11:0] ^ a[23:12] ^ {4'd0, a[31:24]}; // every address bit counts
        if (is_jal_addr(a)) begin
            return {20'd0, 5'd1, 7'b1101111};
        end
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic is_cti(input inst_t w);
        return (w[6:0] == op_jal) || (w[6:0] == op_jalr) || (w[6:0] == op_br);
    endfunction

    task automatic add_row(input string name, input bit restart, input bit hold,
                           input addr_t seed_pc, input bit btb_wr, input addr_t btb_pc,
                           input addr_t btb_tgt, input int n_deq, input logic [7:0] pattern,
                           input int redir_at, input addr_t redir_pc);
        rows[n_rows_loaded] = '{restart: restart, hold: hold, seed_pc: seed_pc,
                                btb_wr: btb_wr, btb_pc: btb_pc, btb_tgt: btb_tgt,
                                n_deq: n_deq, deq_pattern: pattern, redir_at: redir_at,
                                redir_pc: redir_pc};
        names[n_rows_loaded] = name;
        n_rows_loaded++;
    endtask

    task automatic load_table();
        n_rows_loaded = 0;
        add_row("reset_seq", 1'b0, 1'b0, RESET_PC, 1'b0, '0, '0,
                12, 8'b1111_1111, -1, '0);
        add_row("btb_jal", 1'b1, 1'b0, RESET_PC, 1'b1, RESET_PC + 32'h10,
                RESET_PC + 32'h200, 10, 8'b1011_0110, -1, '0);
        add_row("btb_non_branch", 1'b1, 1'b0, RESET_PC + 32'h100, 1'b1, RESET_PC + 32'h108,
                RESET_PC + 32'h300, 6, 8'b1111_0000, -1, '0);
        add_row("btb_alias", 1'b1, 1'b0, RESET_PC + 32'h400, 1'b0, '0, '0,
                8, 8'b0111_1011, -1, '0); // +410 shares an index with +10
        add_row("redirect", 1'b1, 1'b0, RESET_PC + 32'h500, 1'b0, '0, '0,
                9, 8'b0101_0101, 3, RESET_PC + 32'h10);
        add_row("back_pressure", 1'b1, 1'b1, RESET_PC + 32'h600, 1'b0, '0, '0,
                12, 8'b1100_1010, -1, '0);
    endtask

    // memory model side of a request seen this cycle
    task automatic note_request();
        if (imem_req_o) begin
            if (pending) begin
                errors++;
                $display("second request at %h while one is still outstanding", imem_addr_o);
            end
            pending   = 1'b1;
            pend_addr = imem_addr_o;
            countdown = 1 + int'($random(seed) & 32'h3); // 1 to 4 cycles
            req_count++;
        end
    endtask

    task automatic tick(input logic want_deq, input logic want_redir, input addr_t redir_pc,
                        input btb_write_t wr, output logic took, output fetch_entry_t ent);
        @(negedge clk);
        if (redir_prev && empty_o !== 1'b1) begin
            errors++;
            $display("queue not empty in the cycle after a redirect");
        end
        took = want_deq && !want_redir && (empty_o === 1'b0);
        ent  = entry_o;
        imem_resp_i  = 1'b0;
        imem_rdata_i = '0;
        if (pending) begin
            countdown--;
            if (countdown == 0) begin
                imem_resp_i  = 1'b1;
                imem_rdata_i = mem_word(pend_addr);
                pending      = 1'b0;
            end
        end
        redirect_i = '{valid: want_redir, pc: redir_pc};
        btb_wr_i   = wr;
        deq_i      = want_deq && !want_redir;
        redir_prev = want_redir;
        #1;
        note_request();
    endtask

    task automatic check_entry(input string tname, input fetch_entry_t got);
        inst_t      exp_inst;
        logic       exp_taken;
        addr_t      exp_tgt;
        logic [7:0] idx;
        idx       = exp_pc[9:2];
        exp_inst  = mem_word(exp_pc);
        exp_taken = is_cti(exp_inst) && btb_valid_m[idx];
        exp_tgt   = exp_taken ? btb_target_m[idx] : '0;
        checks++;
        if (got.pc !== exp_pc) begin
            errors++;
            $display("Fail %s pc expected %h actual %h", tname, exp_pc, got.pc);
        end
        if (got.inst !== exp_inst) begin
            errors++;
            $display("Fail %s inst expected %h actual %h", tname, exp_inst, got.inst);
        end
        if (got.pred_taken !== exp_taken) begin
            errors++;
            $display("Fail %s pred_taken expected %b actual %b", tname, exp_taken,
                     got.pred_taken);
        end
        if (got.pred_target !== exp_tgt) begin
            errors++;
            $display("Fail %s pred_target expected %h actual %h", tname, exp_tgt,
                     got.pred_target);
        end
        exp_pc = exp_taken ? exp_tgt : exp_pc + 32'd4;
    endtask

    task automatic run_row(input int r);
        scenario_t    row;
        btb_write_t   wr;
        logic         took;
        fetch_entry_t ent;
        int           req_start;
        int           deq_cnt;
        int           guard;
        logic [2:0]   phase;
        logic         hold_deq;
        logic         redir_now;
        logic         redir_done;
        row = rows[r];
        if (row.btb_wr) begin
            wr = '{valid: 1'b1, pc: row.btb_pc, target: row.btb_tgt};
            btb_valid_m[row.btb_pc[9:2]]  = 1'b1;
            btb_target_m[row.btb_pc[9:2]] = row.btb_tgt;
            tick(1'b0, 1'b0, '0, wr, took, ent);
        end
        exp_pc = row.seed_pc;
        if (row.restart) begin
            tick(1'b0, 1'b1, row.seed_pc, '0, took, ent);
        end
        if (row.hold) begin
            req_start = req_count;
            guard     = 0;
            while ((req_count - req_start < QUEUE_DEPTH || pending) && guard < DEQ_TIMEOUT) begin
                tick(1'b0, 1'b0, '0, '0, took, ent);
                guard++;
            end
            if (guard >= DEQ_TIMEOUT) begin
                timeouts++;
                $display("timeout in %s while waiting for the queue to fill", names[r]);
            end
            repeat (20) tick(1'b0, 1'b0, '0, '0, took, ent); // queue stays full
            checks++;
            if (req_count - req_start != QUEUE_DEPTH) begin
                errors++;
                $display("Fail %s requests expected %0d actual %0d", names[r], QUEUE_DEPTH,
                         req_count - req_start);
            end
        end
        deq_cnt    = 0;
        guard      = 0;
        redir_done = 1'b0;
        while (deq_cnt < row.n_deq && guard < DEQ_TIMEOUT) begin
            phase     = 3'(guard);
            hold_deq  = !redir_done && (row.redir_at == deq_cnt);
            redir_now = hold_deq && pending && (countdown > 1); // response still owed
            tick(row.deq_pattern[phase] && !hold_deq, redir_now, row.redir_pc, '0, took, ent);
            if (took) begin
                check_entry(names[r], ent);
                deq_cnt++;
            end
            if (redir_now) begin
                exp_pc     = row.redir_pc;
                redir_done = 1'b1;
            end
            guard++;
        end
        if (deq_cnt < row.n_deq) begin
            timeouts++;
            $display("timeout in %s with %0d of %0d entries dequeued", names[r], deq_cnt,
                     row.n_deq);
        end
    endtask

    initial begin
        rst          = 1'b1;
        imem_resp_i  = 1'b0;
        imem_rdata_i = '0;
        redirect_i   = '0;
        btb_wr_i     = '0;
        deq_i        = 1'b0;
        seed         = 32'h1fa1;
        pending      = 1'b0;
        pend_addr    = '0;
        countdown    = 0;
        req_count    = 0;
        redir_prev   = 1'b0;
        exp_pc       = RESET_PC;
        errors       = 0;
        timeouts     = 0;
        checks       = 0;
        for (int i = 0; i < 256; i++) begin
            btb_valid_m[i]  = 1'b0;
            btb_target_m[i] = '0;
        end
        load_table();

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (i == 7) begin
                rst = 1'b0; // 8 rising edges seen in reset
            end
            #1;
            if (i < 7) begin
                checks++;
                if (imem_req_o !== 1'b0) begin
                    errors++;
                    $display("request issued during reset");
                end
                if (empty_o !== 1'b1) begin
                    errors++;
                    $display("queue not empty during reset");
                end
            end
        end
        checks++;
        if (imem_req_o !== 1'b1) begin
            errors++;
            $display("no request in the first cycle after reset");
        end else if (imem_addr_o !== RESET_PC) begin
            errors++;
            $display("Fail reset first_addr expected %h actual %h", RESET_PC, imem_addr_o);
        end
        note_request();

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/fetch_pkg.sv
rtl/fetch_queue.sv
rtl/btb.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the fetch front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing \
    --top-module fetch_tb \
    -o fetch_sim \
    -f all.f

./obj_dir/fetch_sim > sim.log 2>&1

cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
